// File: hw/event_cmpl_pkg.sv
// shared widths, depths and the FIFO entry type for the completion collector
package event_cmpl_pkg;

    // number of TURFIO completion streams
    localparam int TIO_COUNT = 4;

    // TURFIO beat carries the error field in the low bits and the done address above it
    localparam int TIO_DATA_W = 64;
    localparam int TIO_ERR_W  = 32;

    // header beat carries the error field in the low bits and a 12-bit address above it
    localparam int HDR_DATA_W = 24;
    localparam int HDR_ERR_W  = 8;
    localparam int HDR_ADDR_W = 12;

    // completion address as carried through the FIFOs
    localparam int ADDR_W = 13;

    // width of the outgoing completion stream
    localparam int CMPL_DATA_W = 16;

    // per-source FIFOs are small, the completion FIFO holds a full event buffer
    localparam int TIO_FIFO_DEPTH  = 16;
    localparam int CMPL_FIFO_DEPTH = 4096;

    // must hold 0..CMPL_FIFO_DEPTH
    localparam int CMPL_COUNT_W = 13;

    // reduced beat as stored in the TURFIO and header FIFOs
    // err is the OR of the beat's whole error field
    typedef struct packed {
        logic              err;
        logic [ADDR_W-1:0] addr;
    } cmpl_entry_t;

endpackage

// File: hw/cmpl_sync_fifo.sv
`timescale 1ns/1ps

// first-word-fall-through synchronous FIFO
// the head entry is always presented on dout_o while valid_o is high,
// rd_en_i acts as the pop once the consumer has taken it
module cmpl_sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 16
) (
    input  logic                         memclk,
    input  logic                         memresetn,

    input  logic                         wr_en_i,
    input  payload_t                     din_i,
    output logic                         full_o,

    input  logic                         rd_en_i,
    output payload_t                     dout_o,
    output logic                         valid_o,

    output logic [$clog2(DEPTH+1)-1:0]   count_o
);

    payload_t                          mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]          wr_ptr;
    logic [$clog2(DEPTH)-1:0]          rd_ptr;
    logic [$clog2(DEPTH+1)-1:0]        count_r;
    logic [$clog2(DEPTH+1)-1:0]        count_next;
    logic                              full_r;
    logic                              do_wr;
    logic                              do_rd;

    // writes while full and reads while empty are dropped here
    assign do_wr = wr_en_i && !full_r;
    assign do_rd = rd_en_i && (count_r != '0);

    always_comb begin
        count_next = count_r;
        if (do_wr && !do_rd) begin
            count_next = count_r + 1'b1;
        end else if (do_rd && !do_wr) begin
            count_next = count_r - 1'b1;
        end
    end

    // pointers, occupancy and full flag
    always_ff @(posedge memclk) begin
        if (!memresetn) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count_r <= '0;
            full_r  <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            count_r <= count_next;
            full_r  <= (count_next == DEPTH);
        end
    end

    // storage
    always_ff @(posedge memclk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din_i;
        end
    end

    // fall-through read, so a write shows up one cycle later via count_r
    assign dout_o  = mem[rd_ptr];
    assign valid_o = (count_r != '0);
    assign full_o  = full_r;
    assign count_o = count_r;

endmodule

// File: hw/event_collector_slice.sv
`timescale 1ns/1ps

// register slice for one TURFIO stream
// the 64-bit beat is reduced to its error bit and done address on the way in,
// so both buffer stages only hold the 14-bit entry
module event_collector_slice (
    input  logic                                  memclk,
    input  logic                                  memresetn,

    input  logic                                  s_tvalid_i,
    input  logic [event_cmpl_pkg::TIO_DATA_W-1:0] s_tdata_i,
    output logic                                  s_tready_o,

    output logic                                  m_tvalid_o,
    output event_cmpl_pkg::cmpl_entry_t           m_entry_o,
    input  logic                                  m_tready_i
);

    event_cmpl_pkg::cmpl_entry_t in_entry;
    event_cmpl_pkg::cmpl_entry_t skid_entry;
    logic                        main_valid;
    logic                        skid_valid;
    logic                        accept;
    logic                        main_free;

    // error field sits below the done address
    always_comb begin
        in_entry.err  = |s_tdata_i[event_cmpl_pkg::TIO_ERR_W-1:0];
        in_entry.addr = s_tdata_i[event_cmpl_pkg::TIO_ERR_W +: event_cmpl_pkg::ADDR_W];
    end

    // upstream only sees back-pressure once the skid stage is occupied
    assign s_tready_o = !skid_valid;
    assign accept     = s_tvalid_i && !skid_valid;
    assign main_free  = !main_valid || m_tready_i;
    assign m_tvalid_o = main_valid;

    always_ff @(posedge memclk) begin
        if (!memresetn) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else if (main_free) begin
            // skid entry is older, it moves first
            if (skid_valid) begin
                main_valid <= 1'b1;
                skid_valid <= 1'b0;
            end else begin
                main_valid <= accept;
            end
        end else if (accept) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge memclk) begin
        if (main_free) begin
            if (skid_valid) begin
                m_entry_o <= skid_entry;
            end else if (accept) begin
                m_entry_o <= in_entry;
            end
        end
        if (accept && !main_free) begin
            skid_entry <= in_entry;
        end
    end

endmodule

// File: hw/event_completion_collector.sv
`timescale 1ns/1ps

// completion collector for the memory-side event buffer
// each TURFIO completion and each header beat is reduced to an error bit
// and an address, then buffered. a completion is emitted once the header
// and every unmasked TURFIO have something queued
module event_completion_collector (
    input  logic                                      memclk,
    input  logic                                      memresetn,

    output logic                                      err_any_o,
    output logic [event_cmpl_pkg::CMPL_COUNT_W-1:0]   cmpl_count_o,

    input  logic [event_cmpl_pkg::TIO_COUNT-1:0]      tio_mask_i,

    input  logic                                      s_hdr_tvalid_i,
    input  logic [event_cmpl_pkg::HDR_DATA_W-1:0]     s_hdr_tdata_i,
    output logic                                      s_hdr_tready_o,

    input  logic                                      s_t0_tvalid_i,
    input  logic [event_cmpl_pkg::TIO_DATA_W-1:0]     s_t0_tdata_i,
    output logic                                      s_t0_tready_o,

    input  logic                                      s_t1_tvalid_i,
    input  logic [event_cmpl_pkg::TIO_DATA_W-1:0]     s_t1_tdata_i,
    output logic                                      s_t1_tready_o,

    input  logic                                      s_t2_tvalid_i,
    input  logic [event_cmpl_pkg::TIO_DATA_W-1:0]     s_t2_tdata_i,
    output logic                                      s_t2_tready_o,

    input  logic                                      s_t3_tvalid_i,
    input  logic [event_cmpl_pkg::TIO_DATA_W-1:0]     s_t3_tdata_i,
    output logic                                      s_t3_tready_o,

    output logic                                      m_cmpl_tvalid_o,
    output logic [event_cmpl_pkg::CMPL_DATA_W-1:0]    m_cmpl_tdata_o,
    input  logic                                      m_cmpl_tready_i
);

    // TURFIO side, gathered into arrays for the generate loop
    logic [event_cmpl_pkg::TIO_COUNT-1:0]  tio_in_valid;
    logic [event_cmpl_pkg::TIO_COUNT-1:0]  tio_in_ready;
    logic [event_cmpl_pkg::TIO_DATA_W-1:0] tio_in_data [event_cmpl_pkg::TIO_COUNT];

    logic [event_cmpl_pkg::TIO_COUNT-1:0]  slice_valid;
    event_cmpl_pkg::cmpl_entry_t           slice_entry [event_cmpl_pkg::TIO_COUNT];

    logic [event_cmpl_pkg::TIO_COUNT-1:0]  tio_fifo_full;
    logic [event_cmpl_pkg::TIO_COUNT-1:0]  tio_fifo_valid;
    logic [event_cmpl_pkg::TIO_COUNT-1:0]  tio_fifo_rd;
    logic [event_cmpl_pkg::TIO_COUNT-1:0]  tio_ok;
    event_cmpl_pkg::cmpl_entry_t           tio_fifo_entry [event_cmpl_pkg::TIO_COUNT];

    // header side
    event_cmpl_pkg::cmpl_entry_t           hdr_entry;
    event_cmpl_pkg::cmpl_entry_t           hdr_fifo_entry;
    logic                                  hdr_full;
    logic                                  hdr_valid;

    // join and completion FIFO
    logic                                  join_fire;
    logic                                  cmpl_full;
    logic [event_cmpl_pkg::ADDR_W-1:0]     cmpl_addr;

    // one sticky bit per source, header in the top bit
    logic [event_cmpl_pkg::TIO_COUNT:0]    err_single;
    logic                                  err_any_r;

    assign tio_in_valid = {s_t3_tvalid_i, s_t2_tvalid_i, s_t1_tvalid_i, s_t0_tvalid_i};
    assign tio_in_data[0] = s_t0_tdata_i;
    assign tio_in_data[1] = s_t1_tdata_i;
    assign tio_in_data[2] = s_t2_tdata_i;
    assign tio_in_data[3] = s_t3_tdata_i;
    assign s_t0_tready_o = tio_in_ready[0];
    assign s_t1_tready_o = tio_in_ready[1];
    assign s_t2_tready_o = tio_in_ready[2];
    assign s_t3_tready_o = tio_in_ready[3];

    for (genvar g = 0; g < event_cmpl_pkg::TIO_COUNT; g++) begin : g_tio
        event_collector_slice u_slice (
            .memclk     (memclk),
            .memresetn  (memresetn),
            .s_tvalid_i (tio_in_valid[g]),
            .s_tdata_i  (tio_in_data[g]),
            .s_tready_o (tio_in_ready[g]),
            .m_tvalid_o (slice_valid[g]),
            .m_entry_o  (slice_entry[g]),
            .m_tready_i (!tio_fifo_full[g])
        );

        cmpl_sync_fifo #(
            .payload_t (event_cmpl_pkg::cmpl_entry_t),
            .DEPTH     (event_cmpl_pkg::TIO_FIFO_DEPTH)
        ) u_fifo (
            .memclk    (memclk),
            .memresetn (memresetn),
            .wr_en_i   (slice_valid[g] && !tio_fifo_full[g]),
            .din_i     (slice_entry[g]),
            .full_o    (tio_fifo_full[g]),
            .rd_en_i   (tio_fifo_rd[g]),
            .dout_o    (tio_fifo_entry[g]),
            .valid_o   (tio_fifo_valid[g]),
            .count_o   ()
        );

        // a masked stream counts as present and is drained as it arrives
        assign tio_ok[g]      = tio_fifo_valid[g] || tio_mask_i[g];
        assign tio_fifo_rd[g] = tio_mask_i[g] ? tio_fifo_valid[g] : join_fire;
    end

    // header goes straight into its FIFO, no slice needed
    always_comb begin
        hdr_entry.err  = |s_hdr_tdata_i[event_cmpl_pkg::HDR_ERR_W-1:0];
        hdr_entry.addr = {{(event_cmpl_pkg::ADDR_W - event_cmpl_pkg::HDR_ADDR_W){1'b0}},
                          s_hdr_tdata_i[event_cmpl_pkg::HDR_ERR_W +: event_cmpl_pkg::HDR_ADDR_W]};
    end

    assign s_hdr_tready_o = !hdr_full;

    cmpl_sync_fifo #(
        .payload_t (event_cmpl_pkg::cmpl_entry_t),
        .DEPTH     (event_cmpl_pkg::TIO_FIFO_DEPTH)
    ) u_hdr_fifo (
        .memclk    (memclk),
        .memresetn (memresetn),
        .wr_en_i   (s_hdr_tvalid_i && !hdr_full),
        .din_i     (hdr_entry),
        .full_o    (hdr_full),
        .rd_en_i   (join_fire),
        .dout_o    (hdr_fifo_entry),
        .valid_o   (hdr_valid),
        .count_o   ()
    );

    // addresses are not compared, the header address is what goes out
    assign join_fire = hdr_valid && (&tio_ok) && !cmpl_full;

    always_ff @(posedge memclk) begin
        if (!memresetn) begin
            err_single <= '0;
            err_any_r  <= 1'b0;
        end else begin
            if (join_fire) begin
                for (int k = 0; k < event_cmpl_pkg::TIO_COUNT; k++) begin
                    if (!tio_mask_i[k] && tio_fifo_entry[k].err) begin
                        err_single[k] <= 1'b1;
                    end
                end
                if (hdr_fifo_entry.err) begin
                    err_single[event_cmpl_pkg::TIO_COUNT] <= 1'b1;
                end
            end
            // extra stage keeps the wide OR off the join path
            err_any_r <= |err_single;
        end
    end

    assign err_any_o = err_any_r;

    cmpl_sync_fifo #(
        .payload_t (logic [event_cmpl_pkg::ADDR_W-1:0]),
        .DEPTH     (event_cmpl_pkg::CMPL_FIFO_DEPTH)
    ) u_cmpl_fifo (
        .memclk    (memclk),
        .memresetn (memresetn),
        .wr_en_i   (join_fire),
        .din_i     (hdr_fifo_entry.addr),
        .full_o    (cmpl_full),
        .rd_en_i   (m_cmpl_tvalid_o && m_cmpl_tready_i),
        .dout_o    (cmpl_addr),
        .valid_o   (m_cmpl_tvalid_o),
        .count_o   (cmpl_count_o)
    );

    assign m_cmpl_tdata_o = {{(event_cmpl_pkg::CMPL_DATA_W - event_cmpl_pkg::ADDR_W){1'b0}},
                             cmpl_addr};

endmodule

// File: test/tb_clock_gen.sv
`timescale 1ns/1ps

// free-running memclk and a power-on reset held low for three cycles
module tb_clock_gen (
    output logic memclk,
    output logic memresetn
);

    initial begin
        memclk    = 1'b0;
        memresetn = 1'b0;
        repeat (3) @(posedge memclk);
        #1 memresetn = 1'b1;
    end

    // 4 ns period
    always #2 memclk = ~memclk;

endmodule

// File: test/event_completion_collector_asserts.sv
`timescale 1ns/1ps

// bound into the collector
// rebuilds the join order from the accepted beats and checks the outputs
module event_completion_collector_asserts (
    input logic                                    memclk,
    input logic                                    memresetn,
    input logic [event_cmpl_pkg::TIO_COUNT-1:0]    mask_i,
    input logic                                    hdr_valid_i,
    input logic [event_cmpl_pkg::HDR_DATA_W-1:0]   hdr_data_i,
    input logic                                    hdr_ready_i,
    input logic [event_cmpl_pkg::TIO_COUNT-1:0]    tio_valid_i,
    input logic [event_cmpl_pkg::TIO_DATA_W-1:0]   tio_data_i [event_cmpl_pkg::TIO_COUNT],
    input logic [event_cmpl_pkg::TIO_COUNT-1:0]    tio_ready_i,
    input logic                                    join_fire_i,
    input logic                                    cmpl_valid_i,
    input logic [event_cmpl_pkg::CMPL_DATA_W-1:0]  cmpl_data_i,
    input logic                                    cmpl_ready_i,
    input logic [event_cmpl_pkg::CMPL_COUNT_W-1:0] cmpl_count_i,
    input logic                                    err_any_i
);

    // beats still waiting for a full set, and complete sets in header order
    event_cmpl_pkg::cmpl_entry_t            hdr_q [$];
    logic                                   tio_err_q [event_cmpl_pkg::TIO_COUNT][$];
    event_cmpl_pkg::cmpl_entry_t            set_q [$];

    int                                     fail_count = 0;
    int                                     sets_pending;
    int                                     joined_ahead;
    int                                     count_model;
    logic [event_cmpl_pkg::CMPL_DATA_W-1:0] front_data;
    logic                                   front_err;
    logic                                   err_model;
    logic                                   err_model_d;
    logic                                   out_fire;

    assign out_fire = cmpl_valid_i && cmpl_ready_i;

    always @(posedge memclk) begin
        event_cmpl_pkg::cmpl_entry_t entry;
        logic                        set_ready;
        logic                        err_next;
        int                          ahead;
        if (!memresetn) begin
            hdr_q.delete();
            set_q.delete();
            for (int k = 0; k < event_cmpl_pkg::TIO_COUNT; k++) begin
                tio_err_q[k].delete();
            end
            sets_pending <= 0;
            joined_ahead <= 0;
            count_model  <= 0;
            front_data   <= '0;
            front_err    <= 1'b0;
            err_model    <= 1'b0;
            err_model_d  <= 1'b0;
        end else begin
            ahead    = joined_ahead;
            err_next = err_model;
            // a join always takes the oldest set not joined yet
            if (join_fire_i && ahead < set_q.size()) begin
                err_next = err_next | set_q[ahead].err;
            end
            if (join_fire_i) begin
                ahead++;
            end
            if (out_fire && set_q.size() > 0) begin
                void'(set_q.pop_front());
                ahead--;
            end
            if (hdr_valid_i && hdr_ready_i) begin
                entry.err  = |hdr_data_i[event_cmpl_pkg::HDR_ERR_W-1:0];
                entry.addr = hdr_data_i[event_cmpl_pkg::HDR_ERR_W +: event_cmpl_pkg::HDR_ADDR_W];
                hdr_q.push_back(entry);
            end
            // masked streams take no part in a set
            for (int k = 0; k < event_cmpl_pkg::TIO_COUNT; k++) begin
                if (tio_valid_i[k] && tio_ready_i[k] && !mask_i[k]) begin
                    tio_err_q[k].push_back(|tio_data_i[k][event_cmpl_pkg::TIO_ERR_W-1:0]);
                end
            end
            set_ready = hdr_q.size() > 0;
            for (int k = 0; k < event_cmpl_pkg::TIO_COUNT; k++) begin
                if (!mask_i[k] && tio_err_q[k].size() == 0) begin
                    set_ready = 1'b0;
                end
            end
            if (set_ready) begin
                entry = hdr_q.pop_front();
                for (int k = 0; k < event_cmpl_pkg::TIO_COUNT; k++) begin
                    if (!mask_i[k]) begin
                        entry.err = entry.err | tio_err_q[k].pop_front();
                    end
                end
                set_q.push_back(entry);
            end
            joined_ahead <= ahead;
            sets_pending <= set_q.size();
            count_model  <= count_model + (join_fire_i ? 1 : 0) - (out_fire ? 1 : 0);
            err_model    <= err_next;
            err_model_d  <= err_model;
            if (set_q.size() > 0) begin
                front_data <= set_q[0].addr;
                front_err  <= set_q[0].err;
            end
        end
    end

    a_reset_state: assert property (@(posedge memclk) $rose(memresetn) |->
        !cmpl_valid_i && !err_any_i && cmpl_count_i == '0)
        else begin
            $error("[FAIL] after reset m_cmpl_tvalid_o=%h err_any_o=%h cmpl_count_o=%h",
                   $sampled(cmpl_valid_i), $sampled(err_any_i), $sampled(cmpl_count_i));
            fail_count++;
        end

    a_reset_ready: assert property (@(posedge memclk) $rose(memresetn) |->
        hdr_ready_i && &tio_ready_i)
        else begin
            $error("[FAIL] after reset s_hdr_tready_o=%h s_tn_tready_o=%h",
                   $sampled(hdr_ready_i), $sampled(tio_ready_i));
            fail_count++;
        end

    a_cmpl_data: assert property (@(posedge memclk) disable iff (!memresetn)
        out_fire |-> cmpl_data_i == front_data)
        else begin
            $error("[FAIL] m_cmpl_tdata_o got %h expected %h",
                   $sampled(cmpl_data_i), $sampled(front_data));
            fail_count++;
        end

    a_cmpl_early: assert property (@(posedge memclk) disable iff (!memresetn)
        cmpl_valid_i |-> sets_pending > 0)
        else begin
            $error("completion came out before every unmasked stream delivered a beat");
            fail_count++;
        end

    a_join_set: assert property (@(posedge memclk) disable iff (!memresetn)
        join_fire_i |-> joined_ahead < sets_pending)
        else begin
            $error("join fired without a complete set of accepted beats");
            fail_count++;
        end

    a_cmpl_count: assert property (@(posedge memclk) disable iff (!memresetn)
        cmpl_count_i == count_model)
        else begin
            $error("[FAIL] cmpl_count_o got %h expected %h",
                   $sampled(cmpl_count_i), $sampled(count_model));
            fail_count++;
        end

    a_err_flag: assert property (@(posedge memclk) disable iff (!memresetn)
        err_any_i == err_model_d)
        else begin
            $error("[FAIL] err_any_o got %h expected %h",
                   $sampled(err_any_i), $sampled(err_model_d));
            fail_count++;
        end

    // the head completion is visible while valid is high
    a_err_deadline: assert property (@(posedge memclk) disable iff (!memresetn)
        cmpl_valid_i && front_err |=> err_any_i)
        else begin
            $error("err_any_o still low one cycle after an erroneous completion");
            fail_count++;
        end

endmodule

bind event_completion_collector event_completion_collector_asserts u_checker (
    .memclk       (memclk),
    .memresetn    (memresetn),
    .mask_i       (tio_mask_i),
    .hdr_valid_i  (s_hdr_tvalid_i),
    .hdr_data_i   (s_hdr_tdata_i),
    .hdr_ready_i  (s_hdr_tready_o),
    .tio_valid_i  (tio_in_valid),
    .tio_data_i   (tio_in_data),
    .tio_ready_i  (tio_in_ready),
    .join_fire_i  (join_fire),
    .cmpl_valid_i (m_cmpl_tvalid_o),
    .cmpl_data_i  (m_cmpl_tdata_o),
    .cmpl_ready_i (m_cmpl_tready_i),
    .cmpl_count_i (cmpl_count_o),
    .err_any_i    (err_any_o)
);

// File: test/tb_event_completion_collector.sv
`timescale 1ns/1ps

module tb_event_completion_collector;

    localparam int JOINS_ORDERED = 200;
    localparam int JOINS_MASKED  = 60;
    // per error source, the first ERR_BURST joins carry errors
    localparam int JOINS_ERROR   = 20;
    localparam int ERR_BURST     = 5;
    localparam int JOINS_BACKP   = 120;
    // a join needs a few gap cycles per stream, random ready roughly halves throughput
    localparam int MAX_CYCLES =
        (JOINS_ORDERED + JOINS_MASKED + JOINS_ERROR * (event_cmpl_pkg::TIO_COUNT + 1) +
         JOINS_BACKP) * 16 + 2000;

    logic                                   memclk;
    logic                                   por_resetn;
    logic                                   soft_resetn;
    logic                                   memresetn;
    logic [event_cmpl_pkg::TIO_COUNT-1:0]   tio_mask;
    logic                                   hdr_valid;
    logic [event_cmpl_pkg::HDR_DATA_W-1:0]  hdr_data;
    logic                                   hdr_ready;
    logic [event_cmpl_pkg::TIO_COUNT-1:0]   tio_valid;
    logic [event_cmpl_pkg::TIO_DATA_W-1:0]  tio_data [event_cmpl_pkg::TIO_COUNT];
    logic [event_cmpl_pkg::TIO_COUNT-1:0]   tio_ready;
    logic                                   cmpl_valid;
    logic [event_cmpl_pkg::CMPL_DATA_W-1:0] cmpl_data;
    logic                                   cmpl_ready;
    logic [event_cmpl_pkg::CMPL_COUNT_W-1:0] cmpl_count;
    logic                                   err_any;
    // 0 holds the completion ready low, 1 drives it at random, 2 keeps it high
    int                                     ready_mode = 2;
    logic [31:0]                            rng_state = 32'h26f;
    int                                     out_count = 0;
    int                                     cycle_count = 0;
    int                                     fail_seen = 0;
    int                                     test_count = 0;

    assign memresetn = por_resetn && soft_resetn;

    tb_clock_gen u_clock_gen (
        .memclk    (memclk),
        .memresetn (por_resetn)
    );

    event_completion_collector u_event_completion_collector (
        .memclk          (memclk),
        .memresetn       (memresetn),
        .err_any_o       (err_any),
        .cmpl_count_o    (cmpl_count),
        .tio_mask_i      (tio_mask),
        .s_hdr_tvalid_i  (hdr_valid),
        .s_hdr_tdata_i   (hdr_data),
        .s_hdr_tready_o  (hdr_ready),
        .s_t0_tvalid_i   (tio_valid[0]),
        .s_t0_tdata_i    (tio_data[0]),
        .s_t0_tready_o   (tio_ready[0]),
        .s_t1_tvalid_i   (tio_valid[1]),
        .s_t1_tdata_i    (tio_data[1]),
        .s_t1_tready_o   (tio_ready[1]),
        .s_t2_tvalid_i   (tio_valid[2]),
        .s_t2_tdata_i    (tio_data[2]),
        .s_t2_tready_o   (tio_ready[2]),
        .s_t3_tvalid_i   (tio_valid[3]),
        .s_t3_tdata_i    (tio_data[3]),
        .s_t3_tready_o   (tio_ready[3]),
        .m_cmpl_tvalid_o (cmpl_valid),
        .m_cmpl_tdata_o  (cmpl_data),
        .m_cmpl_tready_i (cmpl_ready)
    );

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    always @(posedge memclk) begin
        #1;
        cmpl_ready = (ready_mode == 2) || (ready_mode == 1 && next_rand() % 2 == 0);
    end

    always @(posedge memclk) begin
        if (!memresetn) begin
            out_count <= 0;
        end else if (cmpl_valid && cmpl_ready) begin
            out_count <= out_count + 1;
        end
    end

    always @(posedge memclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // err_mode 1 sets one random bit of the error field, 0 leaves it clear
    task automatic send_hdr(input int n, input int err_mode, input int max_gap);
        logic [31:0] r;
        for (int i = 0; i < n; i++) begin
            r = next_rand();
            repeat (r % (max_gap + 1)) begin
                @(posedge memclk);
                #1;
            end
            hdr_data  = {r[31:28], r[27:16], (err_mode == 1) ? (8'h01 << r[2:0]) : 8'h00};
            hdr_valid = 1'b1;
            @(posedge memclk);
            while (!hdr_ready) @(posedge memclk);
            #1 hdr_valid = 1'b0;
        end
    endtask

    task automatic send_tio(input int k, input int n, input int err_mode, input int max_gap);
        logic [31:0] r;
        for (int i = 0; i < n; i++) begin
            r = next_rand();
            repeat (r % (max_gap + 1)) begin
                @(posedge memclk);
                #1;
            end
            tio_data[k] = {r[31:13], r[12:0],
                           (err_mode == 1) ? (32'h1 << r[17:13]) : 32'h0};
            tio_valid[k] = 1'b1;
            @(posedge memclk);
            while (!tio_ready[k]) @(posedge memclk);
            #1 tio_valid[k] = 1'b0;
        end
    endtask

    // every stream gets n beats
    // unmasked streams in tio_sel use tio_err, masked ones use masked_err
    task automatic run_streams(input int n, input int hdr_err, input int tio_err,
                               input logic [event_cmpl_pkg::TIO_COUNT-1:0] tio_sel,
                               input int masked_err, input int max_gap);
        int mode [event_cmpl_pkg::TIO_COUNT];
        for (int k = 0; k < event_cmpl_pkg::TIO_COUNT; k++) begin
            mode[k] = tio_mask[k] ? masked_err : (tio_sel[k] ? tio_err : 0);
        end
        fork
            send_hdr(n, hdr_err, max_gap);
            send_tio(0, n, mode[0], max_gap);
            send_tio(1, n, mode[1], max_gap);
            send_tio(2, n, mode[2], max_gap);
            send_tio(3, n, mode[3], max_gap);
        join
    endtask

    task automatic wait_drain(input int n);
        while (out_count < n) @(posedge memclk);
        // give the error flag time to settle
        repeat (3) @(posedge memclk);
        #1;
    endtask

    task automatic pulse_reset(input logic [event_cmpl_pkg::TIO_COUNT-1:0] mask);
        soft_resetn = 1'b0;
        tio_mask    = mask;
        repeat (3) @(posedge memclk);
        #1 soft_resetn = 1'b1;
    endtask

    task automatic report_test(input string name);
        int errs;
        errs = u_event_completion_collector.u_checker.fail_count - fail_seen;
        fail_seen = fail_seen + errs;
        test_count++;
        $display("test %0d %s: %s, %0d assertion failures", test_count, name,
                 (errs == 0) ? "ok" : "errors", errs);
    endtask

    initial begin
        soft_resetn = 1'b1;
        tio_mask    = '0;
        hdr_valid   = 1'b0;
        hdr_data    = '0;
        tio_valid   = '0;
        cmpl_ready  = 1'b1;
        for (int k = 0; k < event_cmpl_pkg::TIO_COUNT; k++) begin
            tio_data[k] = '0;
        end
        wait (por_resetn === 1'b1);
        repeat (4) @(posedge memclk);
        #1;
        report_test("reset state");

        run_streams(JOINS_ORDERED, 0, 0, '0, 0, 5);
        wait_drain(JOINS_ORDERED);
        report_test("ordered pass-through");

        // masked streams carry errors that must stay invisible
        pulse_reset(4'b1010);
        run_streams(JOINS_MASKED, 0, 0, '0, 1, 3);
        wait_drain(JOINS_MASKED);
        report_test("masking");

        // one source at a time carries errors, then clean traffic while the flag has to hold
        // the last pass puts the errors on the header alone
        for (int src = 0; src <= event_cmpl_pkg::TIO_COUNT; src++) begin
            pulse_reset('0);
            run_streams(ERR_BURST, (src == event_cmpl_pkg::TIO_COUNT) ? 1 : 0, 1,
                        {{(event_cmpl_pkg::TIO_COUNT - 1){1'b0}}, 1'b1} << src, 0, 3);
            run_streams(JOINS_ERROR - ERR_BURST, 0, 0, '0, 0, 3);
            wait_drain(JOINS_ERROR);
        end
        report_test("error flag");

        pulse_reset('0);
        ready_mode = 0;
        run_streams(JOINS_BACKP / 2, 0, 0, '0, 0, 1);
        repeat (20) @(posedge memclk);
        #1 ready_mode = 1;
        run_streams(JOINS_BACKP / 2, 0, 0, '0, 0, 1);
        wait_drain(JOINS_BACKP);
        ready_mode = 2;
        report_test("back-pressure");

        $display("tests run: %0d, assertion failures: %0d", test_count, fail_seen);
        if (fail_seen == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: event_completion_collector.f
hw/event_cmpl_pkg.sv
hw/cmpl_sync_fifo.sv
hw/event_collector_slice.sv
hw/event_completion_collector.sv
test/tb_clock_gen.sv
test/event_completion_collector_asserts.sv
test/tb_event_completion_collector.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the completion collector testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_event_completion_collector \
    -f event_completion_collector.f -Mdir obj_dir -o tb_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/tb_sim +verilator+error+limit+1000 2>&1 | tee sim.log

grep -q "RESULT: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
